// File: rtl/cpu_types_pkg.sv
// datapath types for the forwarding slice, imported by every module that carries words or indices
package cpu_types_pkg;

        // basic widths
        localparam int WORD_W    = 32;
        localparam int REG_IDX_W = 5;
        localparam int IMM_W     = 18;

        // architectural register count, x0 included
        localparam int NUM_REGS  = 32;

        typedef logic [WORD_W-1:0]    word_t;
        typedef logic [REG_IDX_W-1:0] reg_idx_t;

        // register-register ops in the low codes
        // immediate ops start at 8
        typedef enum logic [3:0] {
                OP_ADD  = 4'h0,
                OP_SUB  = 4'h1,
                OP_AND  = 4'h2,
                OP_OR   = 4'h3,
                OP_XOR  = 4'h4,
                OP_ADDI = 4'h8,
                OP_XORI = 4'h9
        } opcode_t;

        // register-register layout
        typedef struct packed {
                opcode_t     opcode;
                reg_idx_t    rd;
                reg_idx_t    rs1;
                reg_idx_t    rs2;
                logic [12:0] pad;
        } instr_r_t;

        // register-immediate layout, imm replaces rs2 and pad
        typedef struct packed {
                opcode_t                  opcode;
                reg_idx_t                 rd;
                reg_idx_t                 rs1;
                logic signed [IMM_W-1:0]  imm;
        } instr_i_t;

        // one 32-bit word, two decodes
        // opcode, rd and rs1 sit at the same bits in both views
        typedef union packed {
                instr_r_t r;
                instr_i_t i;
        } instr_u;

endpackage

// File: rtl/exec_alu.sv
// execute stage, decodes the instruction word and computes the result from the forwarded operands
module exec_alu
        import cpu_types_pkg::*, forward_pkg::*;
(
        input  logic     issue_valid,
        input  instr_u   instr,
        input  word_t    operand [NUM_READ_PORTS],

        // toward the memory stage
        output logic     alu_regwen,
        output reg_idx_t alu_rd,
        output word_t    alu_value
);

        word_t   src_a;
        word_t   src_b;
        word_t   imm_ext;
        opcode_t opcode;

        // opcode and rd at the same bits in both views
        assign opcode = instr.r.opcode;
        assign alu_rd = instr.r.rd;

        // bubbles carry no write
        assign alu_regwen = issue_valid;

        // sign extend the 18 bit immediate
        assign imm_ext = {{(WORD_W - IMM_W){instr.i.imm[IMM_W-1]}}, instr.i.imm};

        // port 0 always feeds a
        assign src_a = operand[0];

        // b is the rs2 operand or the immediate
        always_comb begin
                case (opcode)
                        OP_ADDI, OP_XORI: src_b = imm_ext;
                        default:          src_b = operand[1];
                endcase
        end

        // computed every cycle, regwen qualifies it
        always_comb begin
                case (opcode)
                        OP_ADD:  alu_value = src_a + src_b;
                        OP_SUB:  alu_value = src_a - src_b;
                        OP_AND:  alu_value = src_a & src_b;
                        OP_OR:   alu_value = src_a | src_b;
                        OP_XOR:  alu_value = src_a ^ src_b;
                        OP_ADDI: alu_value = src_a + src_b;
                        OP_XORI: alu_value = src_a ^ src_b;
                        default: alu_value = '0;
                endcase
        end

        // an issued instruction must carry a defined opcode
        // idle cycles may hold anything
        always_comb begin
                assert (issue_valid !== 1'b1
                        || opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                          OP_ADDI, OP_XORI})
                else $error("issued undefined opcode %h", opcode);
        end

endmodule

// File: rtl/forward_datapath.sv
// top of the forwarding slice, issue an instruction each cycle and read its result one cycle later
module forward_datapath
        import cpu_types_pkg::*, forward_pkg::*;
(
        input  logic   CLK,
        input  logic   rst_n,
        input  logic   issue_valid,
        input  instr_u instr,
        output logic   result_valid,
        output word_t  result
);

        // read port wiring
        reg_idx_t rsel     [NUM_READ_PORTS];
        word_t    rdata    [NUM_READ_PORTS];
        word_t    operand  [NUM_READ_PORTS];

        // execute to tracker
        logic     alu_regwen;
        reg_idx_t alu_rd;
        word_t    alu_value;

        // tracker stages
        logic     mem_regwen;
        reg_idx_t mem_rd;
        word_t    mem_value;
        logic     wb_regwen;
        reg_idx_t wb_rd;
        word_t    wb_value;

        // sources from the register-register view
        // port 1 is ignored by immediate ops
        assign rsel[0] = instr.r.rs1;
        assign rsel[1] = instr.r.rs2;

        register_file register_file_i (
                .CLK   (CLK),
                .rst_n (rst_n),
                .rsel  (rsel),
                .rdata (rdata),
                .wen   (wb_regwen),
                .wsel  (wb_rd),
                .wdata (wb_value)
        );

        // one forwarding block per read port
        for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : g_fwd
                operand_forward operand_forward_i (
                        .rsel       (rsel[p]),
                        .rf_value   (rdata[p]),
                        .mem_regwen (mem_regwen),
                        .mem_rd     (mem_rd),
                        .mem_value  (mem_value),
                        .wb_regwen  (wb_regwen),
                        .wb_rd      (wb_rd),
                        .wb_value   (wb_value),
                        .operand    (operand[p])
                );
        end

        exec_alu exec_alu_i (
                .issue_valid (issue_valid),
                .instr       (instr),
                .operand     (operand),
                .alu_regwen  (alu_regwen),
                .alu_rd      (alu_rd),
                .alu_value   (alu_value)
        );

        stage_tracker stage_tracker_i (
                .CLK        (CLK),
                .rst_n      (rst_n),
                .alu_regwen (alu_regwen),
                .alu_rd     (alu_rd),
                .alu_value  (alu_value),
                .mem_regwen (mem_regwen),
                .mem_rd     (mem_rd),
                .mem_value  (mem_value),
                .wb_regwen  (wb_regwen),
                .wb_rd      (wb_rd),
                .wb_value   (wb_value)
        );

        // own valid flag, mem_regwen is low for x0 targets
        always_ff @(posedge CLK or negedge rst_n) begin
                if (!rst_n) begin
                        result_valid <= 1'b0;
                end else begin
                        result_valid <= issue_valid;
                end
        end

        // memory stage value, one cycle after issue
        assign result = mem_value;

endmodule

// File: rtl/forward_pkg.sv
// forwarding definitions, imported by the operand select logic and the port arrays
package forward_pkg;

        // one read port per source operand
        // port 0 is rs1, port 1 is rs2
        localparam int NUM_READ_PORTS = 2;

        // operand source select
        // FWD_RF means no pending write matches
        // FWD_WB is the older pending write
        // FWD_MEM is the newest pending write
        // 2'b11 never used
        typedef enum logic [1:0] {
                FWD_RF  = 2'b00,
                FWD_WB  = 2'b01,
                FWD_MEM = 2'b10
        } fwd_sel_t;

        // priority order, highest first
        //   FWD_MEM
        //   FWD_WB
        //   FWD_RF
        // the memory stage holds the younger producer
        // so it must shadow the writeback stage

endpackage

// File: rtl/operand_forward.sv
// operand select for one read port, picks the newest pending write of that register
module operand_forward
        import cpu_types_pkg::*, forward_pkg::*;
(
        input  reg_idx_t rsel,
        input  word_t    rf_value,

        // pending writes from the tracker
        input  logic     mem_regwen,
        input  reg_idx_t mem_rd,
        input  word_t    mem_value,
        input  logic     wb_regwen,
        input  reg_idx_t wb_rd,
        input  word_t    wb_value,

        output word_t    operand
);

        fwd_sel_t sel;

        // no x0 test needed, tracker never enables an x0 write
        // memory stage first, it is the younger producer
        always_comb begin
                if (mem_regwen && (mem_rd == rsel)) begin
                        sel = FWD_MEM;
                end else if (wb_regwen && (wb_rd == rsel)) begin
                        sel = FWD_WB;
                end else begin
                        sel = FWD_RF;
                end
        end

        // operand mux
        always_comb begin
                case (sel)
                        FWD_MEM: operand = mem_value;
                        FWD_WB:  operand = wb_value;
                        default: operand = rf_value;
                endcase
        end

        // x0 is only legal from the register file
        // a pending write must never shadow it
        always_comb begin
                assert (rsel !== '0 || sel == FWD_RF)
                else $error("x0 operand taken from a pending write");
        end

endmodule

// File: rtl/register_file.sv
// 32 entry integer register file with combinational read ports and one clocked write port
module register_file
        import cpu_types_pkg::*, forward_pkg::*;
(
        input  logic     CLK,
        input  logic     rst_n,
        input  reg_idx_t rsel  [NUM_READ_PORTS],
        output word_t    rdata [NUM_READ_PORTS],
        input  logic     wen,
        input  reg_idx_t wsel,
        input  word_t    wdata
);

        // storage
        word_t regs [NUM_REGS];

        // write at the edge that ends writeback
        // no same-cycle bypass, the forwarding path covers that window
        always_ff @(posedge CLK or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < NUM_REGS; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wen) begin
                        regs[wsel] <= wdata;
                end
        end

        // asynchronous reads
        // x0 is hardwired whatever the array holds
        always_comb begin
                for (int p = 0; p < NUM_READ_PORTS; p++) begin
                        if (rsel[p] == '0) begin
                                rdata[p] = '0;
                        end else begin
                                rdata[p] = regs[rsel[p]];
                        end
                end
        end

        // the tracker strips x0 writes before they get here
        a_no_x0_write: assert property (
                @(posedge CLK) disable iff (!rst_n)
                wen |-> (wsel != '0)
        ) else $error("register file write aimed at x0");

endmodule

// File: rtl/stage_tracker.sv
// memory and writeback stage registers holding the pending writes that operands may forward from
module stage_tracker
        import cpu_types_pkg::*;
(
        input  logic     CLK,
        input  logic     rst_n,

        // execute result
        input  logic     alu_regwen,
        input  reg_idx_t alu_rd,
        input  word_t    alu_value,

        // memory stage, newest pending write
        output logic     mem_regwen,
        output reg_idx_t mem_rd,
        output word_t    mem_value,

        // writeback stage, also the register file write port
        output logic     wb_regwen,
        output reg_idx_t wb_rd,
        output word_t    wb_value
);

        // x0 target drops the enable here
        // downstream compares then never see rd of zero with enable set
        logic alu_wen_kept;

        assign alu_wen_kept = alu_regwen && (alu_rd != '0);

        // execute to memory
        // value still moves on a dropped write so the top can report it
        always_ff @(posedge CLK or negedge rst_n) begin
                if (!rst_n) begin
                        mem_regwen <= 1'b0;
                        mem_rd     <= '0;
                        mem_value  <= '0;
                end else begin
                        mem_regwen <= alu_wen_kept;
                        mem_rd     <= alu_rd;
                        mem_value  <= alu_value;
                end
        end

        // memory to writeback
        // memory stage does no work, plain copy
        always_ff @(posedge CLK or negedge rst_n) begin
                if (!rst_n) begin
                        wb_regwen <= 1'b0;
                        wb_rd     <= '0;
                        wb_value  <= '0;
                end else begin
                        wb_regwen <= mem_regwen;
                        wb_rd     <= mem_rd;
                        wb_value  <= mem_value;
                end
        end

        // enable implies a real target in both stages
        a_mem_rd_nonzero: assert property (
                @(posedge CLK) disable iff (!rst_n)
                mem_regwen |-> (mem_rd != '0)
        ) else $error("memory stage write enabled for x0");

        a_wb_rd_nonzero: assert property (
                @(posedge CLK) disable iff (!rst_n)
                wb_regwen |-> (wb_rd != '0)
        ) else $error("writeback stage write enabled for x0");

endmodule

// File: sim/forward_tests.svh
// directed and random test tasks of the forwarding testbench, included inside its module

// one issue slot, checks the slot before it
task automatic drive_step(input logic valid, input instr_u ins, input string name);
        word_t value;
        @(negedge CLK);
        // previous result is stable at the falling edge
        check_bit(pend_name, pend_valid, result_valid);
        if (pend_valid) begin
                check_word(pend_name, pend_value, result);
        end
        issue_valid = valid;
        instr       = ins;
        if (valid) begin
                value = model_exec(ins);
                // x0 result still shows on the output, never stored
                if (ins.r.rd != '0) begin
                        ref_regs[ins.r.rd] = value;
                end
                pend_value = value;
        end
        pend_valid = valid;
        pend_name  = name;
endtask

task automatic issue_reg(input opcode_t op, input int rd, input int rs1, input int rs2,
                         input string name);
        instr_u ins;
        ins          = '0;
        ins.r.opcode = op;
        ins.r.rd     = reg_idx_t'(rd);
        ins.r.rs1    = reg_idx_t'(rs1);
        ins.r.rs2    = reg_idx_t'(rs2);
        drive_step(1'b1, ins, name);
endtask

task automatic issue_imm(input opcode_t op, input int rd, input int rs1, input int imm,
                         input string name);
        instr_u ins;
        ins          = '0;
        ins.i.opcode = op;
        ins.i.rd     = reg_idx_t'(rd);
        ins.i.rs1    = reg_idx_t'(rs1);
        ins.i.imm    = 18'(imm);
        drive_step(1'b1, ins, name);
endtask

task automatic insert_bubble(input string name);
        drive_step(1'b0, '0, name);
endtask

// consumer right behind its producer, memory stage path
task automatic back_to_back_deps();
        issue_imm(OP_ADDI, 1, 0, 100, "b2b seed");
        issue_reg(OP_ADD, 2, 1, 0, "b2b rs1");
        issue_imm(OP_ADDI, 3, 0, 5, "b2b seed2");
        issue_reg(OP_SUB, 4, 1, 3, "b2b rs2");
        issue_reg(OP_ADD, 5, 4, 4, "b2b both");
endtask

// writeback stage path, then register file path
task automatic two_apart_deps();
        issue_imm(OP_ADDI, 6, 0, 'h123, "two apart seed");
        issue_imm(OP_ADDI, 7, 0, 1, "two apart other");
        issue_reg(OP_ADD, 8, 6, 7, "two apart unrelated");
        issue_imm(OP_ADDI, 9, 0, 77, "two apart seed2");
        insert_bubble("two apart bubble");
        issue_reg(OP_OR, 10, 0, 9, "two apart bubble rs2");
        issue_imm(OP_XORI, 11, 0, 'h2aa, "three apart seed");
        insert_bubble("three apart bubble");
        insert_bubble("three apart bubble");
        issue_reg(OP_ADD, 12, 11, 11, "three apart rf");
endtask

// same rd in memory and writeback, newest wins
task automatic same_rd_priority();
        issue_imm(OP_ADDI, 13, 0, 1, "same rd old");
        issue_imm(OP_ADDI, 13, 0, 2, "same rd new");
        issue_reg(OP_ADD, 14, 13, 13, "same rd both");
        issue_imm(OP_ADDI, 15, 15, 1, "chain 1");
        issue_imm(OP_ADDI, 15, 15, 1, "chain 2");
        issue_imm(OP_XORI, 15, 15, 3, "chain 3");
        issue_reg(OP_AND, 16, 15, 13, "chain use");
endtask

// x0 never forwarded, negative immediates
task automatic x0_and_immediates();
        issue_imm(OP_ADDI, 0, 0, 55, "x0 write");
        issue_reg(OP_ADD, 17, 0, 0, "x0 from mem");
        issue_imm(OP_ADDI, 0, 0, 99, "x0 write2");
        insert_bubble("x0 bubble");
        issue_reg(OP_OR, 18, 0, 0, "x0 from wb");
        issue_imm(OP_ADDI, 19, 0, -1, "imm minus one");
        issue_imm(OP_XORI, 20, 19, -2, "imm xori neg");
        issue_imm(OP_ADDI, 21, 20, -131072, "imm most negative");
        issue_reg(OP_SUB, 22, 0, 21, "imm negate");
endtask

// registers 0 to 7 only, so hazards are frequent
task automatic random_stream();
        logic [31:0] r;
        opcode_t     op;
        for (int n = 0; n < RANDOM_COUNT; n++) begin
                r = next_random();
                if (r[31:30] == 2'b00) begin
                        insert_bubble("random bubble");
                end
                r  = next_random();
                op = op_list[r % 7];
                if (op inside {OP_ADDI, OP_XORI}) begin
                        issue_imm(op, r[2:0], r[5:3], $signed(r[26:9]), "random imm");
                end else begin
                        issue_reg(op, r[2:0], r[5:3], r[8:6], "random reg");
                end
        end
endtask

// File: sim/forward_datapath_tb.sv
// testbench for the forwarding slice, runs the directed and random tests against a register model
module forward_datapath_tb
        import cpu_types_pkg::*;
();

        localparam int CLK_PERIOD     = 8;
        localparam int RESET_CYCLES   = 10;
        localparam int RANDOM_COUNT   = 400;
        // upper bound on directed slots, bubbles included
        localparam int DIRECTED_SLOTS = 64;
        // random stream has at most one bubble per instruction
        localparam int WATCHDOG_TIME  =
                CLK_PERIOD * (RESET_CYCLES + DIRECTED_SLOTS + 2 * RANDOM_COUNT + 200);

        logic   CLK;
        logic   rst_n;
        logic   issue_valid;
        instr_u instr;
        logic   result_valid;
        word_t  result;

        // reference registers, updated in program order
        word_t ref_regs [NUM_REGS];

        // slot issued one cycle ago, checked at the next falling edge
        logic  pend_valid;
        word_t pend_value;
        string pend_name;

        logic [31:0] rng_state;
        opcode_t     op_list [7] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_XORI};

        forward_datapath forward_datapath_i (
                .CLK          (CLK),
                .rst_n        (rst_n),
                .issue_valid  (issue_valid),
                .instr        (instr),
                .result_valid (result_valid),
                .result       (result)
        );

        always #(CLK_PERIOD / 2) CLK = ~CLK;

        // 32 bit xorshift
        function automatic logic [31:0] next_random();
                rng_state = rng_state ^ (rng_state << 13);
                rng_state = rng_state ^ (rng_state >> 17);
                rng_state = rng_state ^ (rng_state << 5);
                return rng_state;
        endfunction

        // x0 reads zero
        function automatic word_t ref_read(input reg_idx_t idx);
                if (idx == '0) begin
                        return '0;
                end
                return ref_regs[idx];
        endfunction

        // sequential semantics, no pipeline in the model
        function automatic word_t model_exec(input instr_u ins);
                word_t a;
                word_t b;
                word_t value;
                int    imm;
                a = ref_read(ins.r.rs1);
                b = ref_read(ins.r.rs2);
                // 18 bit signed field widened to int
                imm = $signed(ins.i.imm);
                case (ins.r.opcode)
                        OP_ADD:  value = a + b;
                        OP_SUB:  value = a - b;
                        OP_AND:  value = a & b;
                        OP_OR:   value = a | b;
                        OP_XOR:  value = a ^ b;
                        OP_ADDI: value = a + word_t'(imm);
                        OP_XORI: value = a ^ word_t'(imm);
                        default: value = '0;
                endcase
                return value;
        endfunction

        task automatic check_word(input string name, input word_t expected, input word_t actual);
                assert (actual === expected)
                else begin
                        $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
                        $display("Test failures found");
                        $fatal(1, "result value mismatch");
                end
        endtask

        task automatic check_bit(input string name, input logic expected, input logic actual);
                assert (actual === expected)
                else begin
                        $display("[ERROR] %s result_valid: expected %b, actual %b",
                                 name, expected, actual);
                        $display("Test failures found");
                        $fatal(1, "result valid mismatch");
                end
        endtask

        `include "forward_tests.svh"

        // watchdog
        initial begin
                #(WATCHDOG_TIME);
                $display("Test failures found");
                $fatal(1, "simulation ran past the time allowed for all tests");
        end

        initial begin
                CLK         = 1'b0;
                rst_n       = 1'b0;
                issue_valid = 1'b0;
                instr       = '0;
                pend_valid  = 1'b0;
                pend_value  = '0;
                pend_name   = "reset";
                rng_state   = 32'd66553;
                for (int i = 0; i < NUM_REGS; i++) begin
                        ref_regs[i] = '0;
                end
                repeat (RESET_CYCLES) @(posedge CLK);
                @(negedge CLK);
                rst_n = 1'b1;
                check_bit("reset", 1'b0, result_valid);
                check_word("reset", '0, result);
                back_to_back_deps();
                two_apart_deps();
                same_rd_priority();
                x0_and_immediates();
                random_stream();
                // drain, last result then an empty slot
                insert_bubble("drain");
                insert_bubble("drain");
                $display("All tests passed!");
                $finish;
        end

endmodule

// File: verilog.f
+incdir+sim
rtl/cpu_types_pkg.sv
rtl/forward_pkg.sv
rtl/register_file.sv
rtl/stage_tracker.sv
rtl/operand_forward.sv
rtl/exec_alu.sv
rtl/forward_datapath.sv
sim/forward_datapath_tb.sv
